// File: hdl/rv_pkg.sv
/*
  RV32I shared definitions: major opcodes, control encodings,
  instruction format views and the data bus request types
*/
package rv_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // Operand select encodings
  localparam logic ALU_A_RS1 = 1'b0;
  localparam logic ALU_A_PC  = 1'b1;
  localparam logic ALU_B_RS2 = 1'b0;
  localparam logic ALU_B_IMM = 1'b1;

  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU, ALU_PASS_B
  } alu_func_e;

  typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wb_sel_e;

  typedef enum logic [1:0] {NPC_PLUS4, NPC_PLUS_IMM, NPC_JALR} next_pc_sel_e;

  // Same values as the load/store funct3 field
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_format_e;

  // --------------------------------------------------------------------------
  // Instruction formats, all over the same 32 bits
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } rv_inst_u;

  typedef struct packed {
    alu_func_e    alu_func;
    logic         alu_a_sel;
    logic         alu_b_sel;
    wb_sel_e      wb_sel;
    next_pc_sel_e next_pc_sel;
    logic         reg_write_enable;
    logic         mem_read_enable;
    logic         mem_write_enable;
  } ctl_t;

  // Request as seen on the external data bus
  typedef struct packed {
    logic [XLEN-1:0] address;
    logic [XLEN-1:0] write_data;
    logic [3:0]      byte_enable;
    logic            read_enable;
    logic            write_enable;
  } mem_req_t;

  // Unaligned request before lane steering
  typedef struct packed {
    logic [XLEN-1:0] address;
    logic [XLEN-1:0] store_data;
    mem_format_e     format;
    logic            read_enable;
    logic            write_enable;
  } dmem_req_t;

endpackage

// File: hdl/alu.sv
/*
  RV32I ALU: arithmetic, logic, shifts and compares,
  with a zero flag used for branch decisions
*/
`timescale 1ns/10ps

module alu (
  input  rv_pkg::alu_func_e func,
  input  logic [31:0]       operand_a,
  input  logic [31:0]       operand_b,
  output logic [31:0]       result,
  output logic              result_zero
);

  import rv_pkg::*;

  logic [4:0] shamt;

  // Only the low five bits shift
  assign shamt = operand_b[4:0];

  always_comb begin
    case (func)
      ALU_ADD:    result = operand_a + operand_b;
      ALU_SUB:    result = operand_a - operand_b;
      ALU_SLL:    result = operand_a << shamt;
      ALU_SLT:    result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      ALU_SLTU:   result = {31'b0, operand_a < operand_b};
      ALU_XOR:    result = operand_a ^ operand_b;
      ALU_SRL:    result = operand_a >> shamt;
      ALU_SRA:    result = $unsigned($signed(operand_a) >>> shamt);
      ALU_OR:     result = operand_a | operand_b;
      ALU_AND:    result = operand_a & operand_b;
      ALU_SEQ:    result = {31'b0, operand_a == operand_b};
      ALU_SNE:    result = {31'b0, operand_a != operand_b};
      ALU_SGE:    result = {31'b0, $signed(operand_a) >= $signed(operand_b)};
      ALU_SGEU:   result = {31'b0, operand_a >= operand_b};
      ALU_PASS_B: result = operand_b;
      default:    result = 32'b0;
    endcase
  end

  assign result_zero = (result == 32'b0);

endmodule

// File: hdl/regfile.sv
/*
  Integer register file, two read ports and one write port,
  x0 hardwired to zero
*/
`timescale 1ns/10ps

module regfile (
  input  logic        clock,
  input  logic        write_enable,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_data,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (write_enable && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? 32'b0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'b0 : regs[rs2_addr];

endmodule

// File: hdl/singlecycle_datapath.sv
/*
  Single-cycle datapath: program counter, immediates, operand muxes,
  ALU, branch target adders and register write-back
*/
`timescale 1ns/10ps

module singlecycle_datapath (
  input  logic             clock,
  input  logic             rst_n,
  input  logic [31:0]      inst,
  input  rv_pkg::ctl_t     ctl,
  input  logic [31:0]      load_data,
  output rv_pkg::rv_inst_u decoded,
  output logic             cmp_zero,
  output logic [31:0]      mem_address,
  output logic [31:0]      store_data,
  output logic [31:0]      pc
);

  import rv_pkg::*;

  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [31:0] imm_operand;
  logic [31:0] pc_offset;
  logic [31:0] rs1_data, rs2_data;
  logic [31:0] operand_a, operand_b;
  logic [31:0] alu_result;
  logic [31:0] pc_plus_4, pc_plus_imm;
  logic [31:0] next_pc;
  logic [31:0] wb_data;

  assign decoded = inst;

  // --------------------------------------------------------------------------
  // Immediate generation
  // --------------------------------------------------------------------------
  assign imm_i = {{20{decoded.i.imm_11_0[11]}}, decoded.i.imm_11_0};
  assign imm_s = {{20{decoded.s.imm_11_5[6]}}, decoded.s.imm_11_5, decoded.s.imm_4_0};
  assign imm_b = {{19{decoded.b.imm_12}}, decoded.b.imm_12, decoded.b.imm_11,
                  decoded.b.imm_10_5, decoded.b.imm_4_1, 1'b0};
  assign imm_u = {decoded.u.imm_31_12, 12'b0};
  assign imm_j = {{11{decoded.j.imm_20}}, decoded.j.imm_20, decoded.j.imm_19_12,
                  decoded.j.imm_11, decoded.j.imm_10_1, 1'b0};

  // Immediate for ALU operand B
  always_comb begin
    case (decoded.r.opcode)
      OPC_STORE:           imm_operand = imm_s;
      OPC_LUI, OPC_AUIPC:  imm_operand = imm_u;
      default:             imm_operand = imm_i;
    endcase
  end

  // JAL offset, otherwise the branch offset
  assign pc_offset = (decoded.r.opcode == OPC_JAL) ? imm_j : imm_b;

  regfile u_regfile (
    .clock        (clock),
    .write_enable (ctl.reg_write_enable),
    .rd_addr      (decoded.r.rd),
    .rd_data      (wb_data),
    .rs1_addr     (decoded.r.rs1),
    .rs2_addr     (decoded.r.rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  assign operand_a = (ctl.alu_a_sel == ALU_A_PC) ? pc : rs1_data;
  assign operand_b = (ctl.alu_b_sel == ALU_B_IMM) ? imm_operand : rs2_data;

  alu u_alu (
    .func        (ctl.alu_func),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .result      (alu_result),
    .result_zero (cmp_zero)
  );

  assign mem_address = alu_result;
  assign store_data  = rs2_data;

  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + pc_offset;

  // --------------------------------------------------------------------------
  // Write-back and next pc
  // --------------------------------------------------------------------------
  always_comb begin
    case (ctl.wb_sel)
      WB_MEM:  wb_data = load_data;
      WB_PC4:  wb_data = pc_plus_4;
      WB_IMM:  wb_data = imm_u;
      default: wb_data = alu_result;
    endcase
  end

  always_comb begin
    case (ctl.next_pc_sel)
      NPC_PLUS_IMM: next_pc = pc_plus_imm;
      NPC_JALR:     next_pc = {alu_result[31:1], 1'b0};
      default:      next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// File: hdl/singlecycle_ctlpath.sv
/*
  Single-cycle control path that decodes opcode and function fields
  into datapath selects, ALU function and memory enables
*/
`timescale 1ns/10ps

module singlecycle_ctlpath (
  input  logic             rst_n,
  input  rv_pkg::rv_inst_u decoded,
  input  logic             cmp_zero,
  output rv_pkg::ctl_t     ctl
);

  import rv_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shift_alt;
  alu_func_e  branch_func;
  logic       branch_valid;

  // OP and OP-IMM share the funct3 map
  function automatic alu_func_e op_alu_func(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign funct3 = decoded.r.funct3;
  assign funct7 = decoded.r.funct7;

  // For OP-IMM the funct7 bit only selects SRAI
  assign shift_alt = (funct3 == 3'b101) && funct7[5];

  // Compare that gives zero exactly when the branch is taken
  always_comb begin
    branch_valid = 1'b1;
    case (funct3)
      3'b000: branch_func = ALU_SNE;
      3'b001: branch_func = ALU_SEQ;
      3'b100: branch_func = ALU_SGE;
      3'b101: branch_func = ALU_SLT;
      3'b110: branch_func = ALU_SGEU;
      3'b111: branch_func = ALU_SLTU;
      default: begin
        branch_func  = ALU_SEQ;
        branch_valid = 1'b0;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Main decode
  // --------------------------------------------------------------------------
  always_comb begin
    ctl.alu_func         = ALU_ADD;
    ctl.alu_a_sel        = ALU_A_RS1;
    ctl.alu_b_sel        = ALU_B_RS2;
    ctl.wb_sel           = WB_ALU;
    ctl.next_pc_sel      = NPC_PLUS4;
    ctl.reg_write_enable = 1'b0;
    ctl.mem_read_enable  = 1'b0;
    ctl.mem_write_enable = 1'b0;

    case (decoded.r.opcode)
      OPC_LUI: begin
        ctl.wb_sel           = WB_IMM;
        ctl.reg_write_enable = 1'b1;
      end
      OPC_AUIPC: begin
        ctl.alu_a_sel        = ALU_A_PC;
        ctl.alu_b_sel        = ALU_B_IMM;
        ctl.reg_write_enable = 1'b1;
      end
      OPC_JAL: begin
        ctl.wb_sel           = WB_PC4;
        ctl.next_pc_sel      = NPC_PLUS_IMM;
        ctl.reg_write_enable = 1'b1;
      end
      OPC_JALR: begin
        ctl.alu_b_sel        = ALU_B_IMM;
        ctl.wb_sel           = WB_PC4;
        ctl.next_pc_sel      = NPC_JALR;
        ctl.reg_write_enable = 1'b1;
      end
      OPC_BRANCH: begin
        ctl.alu_func = branch_func;
        if (branch_valid && cmp_zero) begin
          ctl.next_pc_sel = NPC_PLUS_IMM;
        end
      end
      OPC_LOAD: begin
        ctl.alu_b_sel        = ALU_B_IMM;
        ctl.wb_sel           = WB_MEM;
        ctl.reg_write_enable = 1'b1;
        ctl.mem_read_enable  = 1'b1;
      end
      OPC_STORE: begin
        ctl.alu_b_sel        = ALU_B_IMM;
        ctl.mem_write_enable = 1'b1;
      end
      OPC_OP_IMM: begin
        ctl.alu_func         = op_alu_func(funct3, shift_alt);
        ctl.alu_b_sel        = ALU_B_IMM;
        ctl.reg_write_enable = 1'b1;
      end
      OPC_OP: begin
        ctl.alu_func         = op_alu_func(funct3, funct7[5]);
        ctl.reg_write_enable = 1'b1;
      end
      // Fences, system calls and unknown opcodes retire with no effect
      default: ;
    endcase

    if (!rst_n) begin
      ctl.reg_write_enable = 1'b0;
      ctl.mem_read_enable  = 1'b0;
      ctl.mem_write_enable = 1'b0;
    end
  end

endmodule

// File: hdl/data_memory_interface.sv
/*
  Data memory interface: steers store data into byte lanes,
  forms byte enables and extends load data by access format
*/
`timescale 1ns/10ps

module data_memory_interface (
  input  rv_pkg::dmem_req_t req,
  input  logic [31:0]       bus_read_data,
  output rv_pkg::mem_req_t  bus_req,
  output logic [31:0]       load_data
);

  import rv_pkg::*;

  logic [1:0]  offset;
  logic [31:0] lane_data;
  logic [3:0]  byte_enable;
  logic [31:0] shifted;

  assign offset = req.address[1:0];

  // --------------------------------------------------------------------------
  // Store side
  // --------------------------------------------------------------------------
  // Size is in the low two format bits, signedness is irrelevant here
  always_comb begin
    case (req.format[1:0])
      2'b00: begin
        lane_data   = {4{req.store_data[7:0]}};
        byte_enable = 4'b0001 << offset;
      end
      2'b01: begin
        lane_data   = {2{req.store_data[15:0]}};
        byte_enable = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        lane_data   = req.store_data;
        byte_enable = 4'b1111;
      end
    endcase
  end

  always_comb begin
    bus_req.address      = {req.address[31:2], 2'b00};
    bus_req.write_data   = lane_data;
    bus_req.byte_enable  = byte_enable;
    bus_req.read_enable  = req.read_enable;
    bus_req.write_enable = req.write_enable;
  end

  // --------------------------------------------------------------------------
  // Load side
  // --------------------------------------------------------------------------
  assign shifted = bus_read_data >> {offset, 3'b000};

  always_comb begin
    case (req.format)
      MEM_B:   load_data = {{24{shifted[7]}}, shifted[7:0]};
      MEM_H:   load_data = {{16{shifted[15]}}, shifted[15:0]};
      MEM_BU:  load_data = {24'b0, shifted[7:0]};
      MEM_HU:  load_data = {16'b0, shifted[15:0]};
      default: load_data = shifted;
    endcase
  end

endmodule

// File: hdl/riscv_core.sv
/*
  Single-cycle RV32I core, joins datapath, control path and
  data memory interface to the fetch port and the data bus
*/
`timescale 1ns/10ps

module riscv_core (
  input  logic             clock,
  input  logic             rst_n,
  input  logic [31:0]      inst,
  output logic [31:0]      pc,
  output rv_pkg::mem_req_t bus_req,
  input  logic [31:0]      bus_read_data
);

  import rv_pkg::*;

  rv_inst_u    decoded;
  ctl_t        ctl;
  logic        cmp_zero;
  logic [31:0] mem_address;
  logic [31:0] store_data;
  logic [31:0] load_data;
  dmem_req_t   dmem_req;

  singlecycle_datapath u_datapath (
    .clock       (clock),
    .rst_n       (rst_n),
    .inst        (inst),
    .ctl         (ctl),
    .load_data   (load_data),
    .decoded     (decoded),
    .cmp_zero    (cmp_zero),
    .mem_address (mem_address),
    .store_data  (store_data),
    .pc          (pc)
  );

  singlecycle_ctlpath u_ctlpath (
    .rst_n    (rst_n),
    .decoded  (decoded),
    .cmp_zero (cmp_zero),
    .ctl      (ctl)
  );

  // Access format is the load/store funct3
  assign dmem_req = '{
    address:      mem_address,
    store_data:   store_data,
    format:       mem_format_e'(decoded.r.funct3),
    read_enable:  ctl.mem_read_enable,
    write_enable: ctl.mem_write_enable
  };

  data_memory_interface u_dmem (
    .req           (dmem_req),
    .bus_read_data (bus_read_data),
    .bus_req       (bus_req),
    .load_data     (load_data)
  );

endmodule

// File: testbench/tb_clock_gen.sv
/*
  Testbench clock and reset, 20 ns period, reset held for two cycles
*/
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clock,
  output logic rst_n
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clock);
    #2 rst_n = 1'b1;
  end

endmodule

// File: testbench/tb_riscv_core.sv
/*
  Testbench for the single-cycle RV32I core that runs a table of program
  steps and checks pc and every data bus request against expected values
*/
`timescale 1ns/10ps

module tb_riscv_core;

  import rv_pkg::*;

  localparam logic [1:0] K_NONE  = 2'd0;
  localparam logic [1:0] K_LOAD  = 2'd1;
  localparam logic [1:0] K_STORE = 2'd2;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [1:0]  kind;
    mem_req_t    req;
  } step_t;

  logic        clock;
  logic        rst_n;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] bus_read_data;
  mem_req_t    bus_req;

  logic [31:0] dmem [0:63];
  step_t       steps [0:127];
  int          n_rows;
  int          errors;
  int          checks;
  logic [31:0] cur_pc;
  logic [31:0] dst_off;
  logic [31:0] lfsr_state;
  logic        table_ready;

  tb_clock_gen u_clock_gen (
    .clock (clock),
    .rst_n (rst_n)
  );

  riscv_core DUT (
    .clock         (clock),
    .rst_n         (rst_n),
    .inst          (inst),
    .pc            (pc),
    .bus_req       (bus_req),
    .bus_read_data (bus_read_data)
  );

  // --------------------------------------------------------------------------
  // Data memory model with combinational read and byte-enabled write
  // --------------------------------------------------------------------------
  assign bus_read_data = dmem[bus_req.address[7:2]];

  always @(posedge clock) begin
    if (bus_req.write_enable === 1'b1) begin
      for (int b = 0; b < 4; b++) begin
        if (bus_req.byte_enable[b]) begin
          dmem[bus_req.address[7:2]][8*b +: 8] <= bus_req.write_data[8*b +: 8];
        end
      end
    end
  end

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) begin
      s = s ^ 32'h8020_0003;
    end
    return s;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [31:0] imm, input int rs1, input int f3,
                                        input int rd, input logic [6:0] opc);
    return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, input int rs2, input int f3);
    return {imm[11:5], 5'(rs2), 5'd0, 3'(f3), imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [31:0] imm, input int rs2, input int rs1,
                                        input int f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
  endfunction

  // Byte lanes and enables of a store by access size
  function automatic logic [31:0] lane_data(input logic [31:0] v, input logic [2:0] f3);
    case (f3[1:0])
      2'b00:   return {4{v[7:0]}};
      2'b01:   return {2{v[15:0]}};
      default: return v;
    endcase
  endfunction

  // One enable per accessed byte, starting at the byte offset
  function automatic logic [3:0] lane_enables(input logic [1:0] off, input logic [2:0] f3);
    logic [3:0] mask;
    case (f3[1:0])
      2'b00:   mask = 4'b0001;
      2'b01:   mask = 4'b0011;
      default: mask = 4'b1111;
    endcase
    return mask << off;
  endfunction

  function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] off,
                                              input logic [2:0] f3);
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    byte_val = word[8*off +: 8];
    half_val = off[1] ? word[31:16] : word[15:0];
    case (f3)
      3'd0:    return {{24{byte_val[7]}}, byte_val};
      3'd1:    return {{16{half_val[15]}}, half_val};
      3'd4:    return {24'b0, byte_val};
      3'd5:    return {16'b0, half_val};
      default: return word;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Table building
  // --------------------------------------------------------------------------
  task automatic add_step(input logic [31:0] code, input logic [1:0] kind, input mem_req_t req,
                          input logic [31:0] next_pc);
    steps[n_rows] = '{cur_pc, code, kind, req};
    n_rows++;
    cur_pc = next_pc;
  endtask

  task automatic plain(input logic [31:0] code);
    add_step(code, K_NONE, '0, cur_pc + 32'd4);
  endtask

  task automatic store(input int f3, input int rs2, input logic [31:0] off, input logic [31:0] v);
    mem_req_t req;
    req = '{{off[31:2], 2'b00}, lane_data(v, 3'(f3)), lane_enables(off[1:0], 3'(f3)), 1'b0, 1'b1};
    add_step(enc_s(off, rs2, f3), K_STORE, req, cur_pc + 32'd4);
  endtask

  // Result stores go to consecutive words
  task automatic store_word(input int rs2, input logic [31:0] v);
    store(2, rs2, dst_off, v);
    dst_off = dst_off + 32'd4;
  endtask

  task automatic load_and_store(input int f3, input logic [31:0] off);
    mem_req_t req;
    logic [31:0] v;
    v = extend_load(dmem[off[7:2]], off[1:0], 3'(f3));
    req = '{{off[31:2], 2'b00}, 32'b0, lane_enables(off[1:0], 3'(f3)), 1'b1, 1'b0};
    add_step(enc_i(off, 0, f3, 20, 7'h03), K_LOAD, req, cur_pc + 32'd4);
    store_word(20, v);
  endtask

  task automatic branch(input int f3, input int rs1, input int rs2, input bit taken);
    add_step(enc_b(32'd8, rs2, rs1, f3), K_NONE, '0, taken ? cur_pc + 32'd8 : cur_pc + 32'd4);
  endtask

  task automatic build_program();
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v4;
    logic [31:0] link;
    cur_pc  = RESET_PC;
    dst_off = 32'h0;
    v1 = 32'h123;
    v2 = 32'h8000_0000;
    v4 = 32'hFFFF_FFFB;
    plain(enc_i(v1, 0, 0, 1, 7'h13));
    plain({20'h80000, 5'd2, 7'h37});
    link = cur_pc + 32'h1000;
    plain({20'h00001, 5'd3, 7'h17});
    plain(enc_i(v4, 0, 0, 4, 7'h13));
    plain(enc_i(32'd4, 0, 0, 8, 7'h13));
    store_word(1, v1);
    store_word(2, v2);
    store_word(3, link);
    store_word(4, v4);
    // Register-register ops with each result stored
    plain(enc_r(0, 4, 1, 0, 5));
    store_word(5, v1 + v4);
    plain(enc_r(32, 4, 1, 0, 6));
    store_word(6, v1 - v4);
    plain(enc_r(0, 8, 1, 1, 7));
    store_word(7, 32'h1230);
    plain(enc_r(0, 8, 2, 5, 9));
    store_word(9, 32'h0800_0000);
    plain(enc_r(32, 8, 2, 5, 10));
    store_word(10, 32'hF800_0000);
    plain(enc_r(0, 1, 4, 2, 11));
    store_word(11, 32'd1);
    plain(enc_r(0, 1, 4, 3, 12));
    store_word(12, 32'd0);
    plain(enc_r(0, 4, 1, 4, 13));
    store_word(13, v1 ^ v4);
    plain(enc_r(0, 4, 1, 6, 14));
    store_word(14, v1 | v4);
    plain(enc_r(0, 4, 1, 7, 15));
    store_word(15, v1 & v4);
    plain(enc_i(32'h41F, 2, 5, 16, 7'h13));
    store_word(16, 32'hFFFF_FFFF);
    plain(enc_i(32'd8, 1, 1, 17, 7'h13));
    store_word(17, 32'h1_2300);
    plain(enc_i(32'd5, 0, 0, 0, 7'h13));
    store_word(0, 32'd0);
    // Loads from the untouched upper half
    load_and_store(0, 32'h81);
    load_and_store(0, 32'h82);
    load_and_store(4, 32'h83);
    load_and_store(4, 32'h80);
    load_and_store(1, 32'h86);
    load_and_store(1, 32'h84);
    load_and_store(5, 32'h8A);
    load_and_store(2, 32'h8C);
    // Partial stores at every offset
    for (int k = 0; k < 4; k++) begin
      store(0, 1, 32'h70 + 32'(k), v1);
    end
    store(1, 13, 32'h74, v1 ^ v4);
    store(1, 13, 32'h76, v1 ^ v4);
    store(2, 4, 32'h78, v4);
    // Each branch taken and then not taken
    branch(0, 1, 1, 1'b1);
    branch(0, 1, 4, 1'b0);
    branch(1, 1, 4, 1'b1);
    branch(1, 1, 1, 1'b0);
    branch(4, 4, 1, 1'b1);
    branch(4, 1, 4, 1'b0);
    branch(5, 1, 4, 1'b1);
    branch(5, 4, 1, 1'b0);
    branch(6, 1, 4, 1'b1);
    branch(6, 4, 1, 1'b0);
    branch(7, 4, 1, 1'b1);
    branch(7, 1, 4, 1'b0);
    link = cur_pc + 32'd4;
    add_step(enc_j(32'd16, 25), K_NONE, '0, cur_pc + 32'd16);
    store_word(25, link);
    plain(enc_i(32'h301, 0, 0, 27, 7'h13));
    link = cur_pc + 32'd4;
    // Target bit 0 is cleared
    add_step(enc_i(32'd0, 27, 0, 26, 7'h67), K_NONE, '0, 32'h300);
    store_word(26, link);
    plain(32'h0000_0013);
  endtask

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input int row);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: step %0d pc %h, expected %h", $time, row, got, exp);
    end
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t exp, input logic [1:0] kind,
                           input int row);
    bit bad;
    checks++;
    if (kind == K_NONE) begin
      bad = (got.read_enable !== 1'b0) || (got.write_enable !== 1'b0);
    end else if (kind == K_LOAD) begin
      bad = (got.address !== exp.address) || (got.byte_enable !== exp.byte_enable) ||
            (got.read_enable !== 1'b1) || (got.write_enable !== 1'b0);
    end else begin
      bad = (got !== exp);
    end
    if (bad) begin
      errors++;
      $display("FAIL %0t: step %0d bus request %h, expected %h", $time, row, got, exp);
    end
  endtask

  initial begin
    wait (table_ready === 1'b1);
    #((n_rows + 12) * 20);
    $display("Watchdog expired before the program table finished");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    table_ready = 1'b0;
    inst        = enc_s(32'd0, 1, 2);
    errors      = 0;
    checks      = 0;
    n_rows      = 0;
    lfsr_state  = 32'd96318;
    for (int w = 0; w < 64; w++) begin
      for (int b = 0; b < 32; b++) begin
        dmem[w][b] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
      end
    end
    build_program();
    table_ready = 1'b1;

    // Enables stay low while reset is held
    #6;
    check_req(bus_req, '0, K_NONE, -1);
    @(posedge clock);
    #2;
    inst = enc_i(32'h80, 0, 2, 5, 7'h03);
    #6;
    check_pc(pc, RESET_PC, -1);
    check_req(bus_req, '0, K_NONE, -1);

    wait (rst_n === 1'b1);
    for (int i = 0; i < n_rows; i++) begin
      inst = steps[i].inst;
      #6;
      check_pc(pc, steps[i].pc, i);
      check_req(bus_req, steps[i].req, steps[i].kind, i);
      @(posedge clock);
      #2;
    end

    $display("Errors: %0d in %0d checks over %0d steps", errors, checks, n_rows);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
hdl/rv_pkg.sv
hdl/alu.sv
hdl/regfile.sv
hdl/singlecycle_datapath.sv
hdl/singlecycle_ctlpath.sv
hdl/data_memory_interface.sv
hdl/riscv_core.sv
testbench/tb_clock_gen.sv
testbench/tb_riscv_core.sv

// File: Makefile
# Verilator simulation of the single-cycle RV32I core

VERILATOR ?= verilator
TOP       ?= tb_riscv_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)
